// File: vlog.f
hw/msi_pkg.sv
hw/regbus_pkg.sv
hw/msi_prio_fifo.sv
hw/msi_vector_table.sv
hw/msi_dispatch.sv
hw/msi_regs.sv
hw/msi_controller.sv
bench/tb_clkgen.sv
bench/tb_msi_controller.sv

// File: Makefile
TOP := tb_msi_controller

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_msi_controller.sv
`timescale 1ns/1ps

module tb_msi_controller;
	import msi_pkg::*;
	import regbus_pkg::*;

	localparam int NQUES  = 7;
	localparam int QDEPTH = 4;

	logic             clk;
	logic             rst;
	logic             msg_valid;
	msi_msg_t         msg;
	logic [NQUES-1:0] credit;
	regbus_req_t      reg_req;
	regbus_resp_t     reg_resp;
	logic             irq;
	logic             irq_ack;
	msi_ivect_t       ivect;
	logic [2:0]       ipri;
	logic [2:0]       swstk;

	// ====================
	// reference model
	// ====================
	msi_vec_t    tbl_model [64];	// what the table should hold
	logic [63:0] en_model;
	logic [63:0] pend_model;
	int          credits [NQUES];	// sender side credit count
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          errors_at_start = 0;

	tb_clkgen #(.PERIOD(10), .RST_CYCLES(5)) u_clkgen (.clk(clk), .rst(rst));

	msi_controller #(
		.NQUES  (NQUES),
		.QDEPTH (QDEPTH)
	) msi_controller_inst (
		.clk         (clk),
		.rst         (rst),
		.msg_valid_i (msg_valid),
		.msg_i       (msg),
		.credit_o    (credit),
		.reg_req_i   (reg_req),
		.reg_resp_o  (reg_resp),
		.irq_o       (irq),
		.ivect_o     (ivect),
		.ipri_o      (ipri),
		.swstk_o     (swstk),
		.irq_ack_i   (irq_ack)
	);

	// credits come back one per pulse, sampled mid cycle
	always @(negedge clk) begin
		for (int q = 0; q < NQUES; q++)
			if (!rst && credit[q])
				credits[q]++;
	end

	// priorities past the last queue share the last queue
	function automatic int queue_of(input logic [2:0] pri);
		return (int'(pri) >= NQUES) ? NQUES - 1 : int'(pri);
	endfunction

	function automatic logic [31:0] ctrl_word(input logic gen, input logic [2:0] thr);
		return {25'd0, thr, 3'd0, gen};
	endfunction

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic require(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == errors_at_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	// ====================
	// bus and message drivers
	// ====================
	task automatic access_reg(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		regbus_req_t r;
		bit got;
		r = '0;
		r.valid = 1'b1;
		r.we = we;
		r.addr = addr;
		r.wdata = wdata;
		got = 1'b0;
		rdata = '0;
		@(posedge clk);
		reg_req <= r;
		@(posedge clk);
		reg_req <= '0;	// one request only
		for (int t = 0; t < 4 && !got; t++) begin
			@(negedge clk);
			got = reg_resp.valid;
		end
		require(got, $sformatf("no register bus response for address 0x%02h", addr));
		rdata = reg_resp.rdata;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		access_reg(1'b1, addr, data, unused);
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
		access_reg(1'b0, addr, 32'd0, data);
	endtask

	task automatic send_msg(input logic [5:0] vec, input logic [2:0] pri, input logic [15:0] data,
			input bit drop);
		msi_msg_t m;
		int q;
		q = queue_of(pri);
		if (!drop) begin	// a dropped message never held a credit
			require(credits[q] > 0, $sformatf("message sent to queue %0d without a credit", q));
			credits[q]--;
		end
		pend_model[vec] = 1'b1;	// pending even when dropped
		m.vecno = vec;
		m.pri = pri;
		m.data = data;
		@(posedge clk);
		msg_valid <= 1'b1;
		msg <= m;
		@(posedge clk);
		msg_valid <= 1'b0;
	endtask

	task automatic set_vector(input int v, input logic ie, input logic en);
		msi_vec_t e;
		e.ie = ie;
		e.swstk = 3'($urandom);
		e.handler = 28'($urandom);
		tbl_model[v] = e;
		en_model[v] = en;
		write_reg(REG_VTBL + 8'(v), e);
		write_reg(REG_EN0, en_model[31:0]);
		write_reg(REG_EN1, en_model[63:32]);
	endtask

	task automatic expect_irq(input int v, input logic [15:0] data, input int q, input int max);
		bit ok;
		ok = 1'b0;
		for (int t = 0; t < max && !ok; t++) begin
			@(negedge clk);
			ok = irq;
		end
		require(ok, $sformatf("timeout waiting for irq_o, vector %0d", v));
		if (ok) begin
			compare("ivect_o.handler", 64'(ivect.handler), 64'(tbl_model[v].handler));
			compare("ivect_o.data", 64'(ivect.data), 64'(data));
			compare("ipri_o", 64'(ipri), 64'(q));
			compare("swstk_o", 64'(swstk), 64'(tbl_model[v].swstk));
		end
	endtask

	// one cycle ack, credit shows while it is high
	task automatic ack_irq(input int q);
		@(posedge clk);
		irq_ack <= 1'b1;
		@(negedge clk);
		compare("credit_o", 64'(credit), 64'(1) << q);
		@(posedge clk);
		irq_ack <= 1'b0;
		@(negedge clk);
		compare("irq_o", 64'(irq), 64'(0));	// dropped after the ack
	endtask

	task automatic pend_check();
		logic [31:0] rd;
		read_reg(REG_PEND0, rd);
		compare("pending 0..31", 64'(rd), 64'(pend_model[31:0]));
		read_reg(REG_PEND1, rd);
		compare("pending 32..63", 64'(rd), 64'(pend_model[63:32]));
	endtask

	task automatic clear_pending();
		write_reg(REG_PEND0, 32'hffff_ffff);
		write_reg(REG_PEND1, 32'hffff_ffff);
		pend_model = '0;
	endtask

	// ====================
	// tests
	// ====================
	task automatic reset_state();
		logic [31:0] rd;
		logic [7:0] regs [6];
		regs = '{REG_CTRL, REG_STATUS, REG_EN0, REG_EN1, REG_PEND0, REG_PEND1};
		for (int t = 0; t < 5; t++) begin
			@(negedge clk);
			compare("irq_o", 64'(irq), 64'(0));
			compare("credit_o", 64'(credit), 64'(0));
			compare("reg_resp_o.valid", 64'(reg_resp.valid), 64'(0));
		end
		foreach (regs[i]) begin
			read_reg(regs[i], rd);
			compare($sformatf("register 0x%02h", regs[i]), 64'(rd), 64'(0));
		end
		report_test("reset state");
	endtask

	task automatic register_access();
		logic [31:0] rd;
		for (int v = 0; v < 64; v++) begin
			tbl_model[v] = msi_vec_t'($urandom);
			write_reg(REG_VTBL + 8'(v), tbl_model[v]);
		end
		en_model = {$urandom, $urandom};
		write_reg(REG_EN0, en_model[31:0]);
		write_reg(REG_EN1, en_model[63:32]);
		for (int v = 0; v < 64; v++) begin
			read_reg(REG_VTBL + 8'(v), rd);
			compare($sformatf("vector entry %0d", v), 64'(rd), 64'(tbl_model[v]));
		end
		read_reg(REG_EN0, rd);
		compare("enable 0..31", 64'(rd), 64'(en_model[31:0]));
		read_reg(REG_EN1, rd);
		compare("enable 32..63", 64'(rd), 64'(en_model[63:32]));
		write_reg(8'h20, 32'hffff_ffff);	// unmapped, ignored
		read_reg(8'h20, rd);
		compare("unmapped 0x20", 64'(rd), 64'(0));
		report_test("register access");
	endtask

	task automatic single_dispatch();
		int v;
		logic [2:0] pri;
		logic [15:0] dat;
		v = int'($urandom % 64);
		pri = 3'($urandom);
		dat = 16'($urandom);
		write_reg(REG_CTRL, ctrl_word(1'b1, 3'd0));
		set_vector(v, 1'b1, 1'b1);
		send_msg(6'(v), pri, dat, 1'b0);
		expect_irq(v, dat, queue_of(pri), 5);	// fixed latency bound
		pend_check();
		ack_irq(queue_of(pri));
		write_reg((v < 32) ? REG_PEND0 : REG_PEND1, 32'(1) << v[4:0]);
		pend_model[v] = 1'b0;
		pend_check();
		report_test("single dispatch");
	endtask

	task automatic priority_order();
		int vecs [8];
		logic [2:0] pris [8];
		logic [15:0] dats [8];
		int order [$];
		write_reg(REG_CTRL, ctrl_word(1'b1, 3'd7));	// nothing reaches 7, dispatch held
		for (int i = 0; i < 8; i++) begin
			vecs[i] = 8 + i;
			pris[i] = 3'($urandom);
			for (int k = 0; k < 8 && credits[queue_of(pris[i])] == 0; k++)
				pris[i] = pris[i] + 3'd1;	// skip a queue with no credit left
			dats[i] = {8'($urandom), 8'(i)};	// low byte tags arrival order
			set_vector(vecs[i], 1'b1, 1'b1);
			send_msg(6'(vecs[i]), pris[i], dats[i], 1'b0);
		end
		// highest queue first, arrival order inside a queue
		for (int q = NQUES - 1; q >= 0; q--)
			for (int i = 0; i < 8; i++)
				if (queue_of(pris[i]) == q)
					order.push_back(i);
		write_reg(REG_CTRL, ctrl_word(1'b1, 3'd0));
		foreach (order[n]) begin
			expect_irq(vecs[order[n]], dats[order[n]], queue_of(pris[order[n]]), 20);
			ack_irq(queue_of(pris[order[n]]));
		end
		pend_check();
		clear_pending();
		report_test("priority order");
	endtask

	task automatic gating();
		int q;
		bit returned;
		bit raised;
		logic [2:0] pri;
		write_reg(REG_CTRL, ctrl_word(1'b1, 3'd0));
		for (int c = 0; c < 3; c++) begin
			set_vector(20 + c, c != 0, c != 1);	// case 0 ie off, case 1 enable bit off
			if (c == 2)
				write_reg(REG_CTRL, ctrl_word(1'b0, 3'd0));	// case 2 global enable off
			pri = 3'($urandom);
			q = queue_of(pri);
			returned = 1'b0;
			raised = 1'b0;
			send_msg(6'(20 + c), pri, 16'($urandom), 1'b0);
			for (int t = 0; t < 20 && !returned; t++) begin
				@(negedge clk);
				raised |= irq;
				returned = credit[q];
			end
			require(returned, $sformatf("credit not returned for gated case %0d", c));
			require(!raised, $sformatf("irq_o raised for disabled vector, case %0d", c));
		end
		write_reg(REG_CTRL, ctrl_word(1'b1, 3'd0));
		pend_check();	// discarded vectors stay pending
		clear_pending();
		report_test("gating");
	endtask

	task automatic overflow();
		logic [2:0] p;
		logic [31:0] rd;
		bit raised;
		p = 3'($urandom % NQUES);
		raised = 1'b0;
		write_reg(REG_CTRL, ctrl_word(1'b1, 3'd7));
		set_vector(30, 1'b1, 1'b1);
		for (int i = 0; i <= QDEPTH; i++)
			send_msg(6'd30, p, 16'(i), i == QDEPTH);	// last one finds the queue full
		read_reg(REG_STATUS, rd);
		compare("status", 64'(rd), 64'(1) << queue_of(p));
		write_reg(REG_STATUS, ~(32'(1) << queue_of(p)));	// zero clears
		read_reg(REG_STATUS, rd);
		compare("status", 64'(rd), 64'(0));
		write_reg(REG_CTRL, ctrl_word(1'b1, 3'd0));
		for (int i = 0; i < QDEPTH; i++) begin
			expect_irq(30, 16'(i), queue_of(p), 20);
			ack_irq(queue_of(p));
		end
		for (int t = 0; t < 20; t++) begin
			@(negedge clk);
			raised |= irq;
		end
		require(!raised, "interrupt raised for the dropped message");
		clear_pending();
		report_test("overflow");
	endtask

	initial begin
		int seed;
		seed = int'($urandom(45356));
		msg_valid = 1'b0;
		msg = '0;
		reg_req = '0;
		irq_ack = 1'b0;
		pend_model = '0;
		en_model = '0;
		foreach (credits[q])
			credits[q] = QDEPTH;
		for (int t = 0; t < 20 && rst !== 1'b0; t++)
			@(posedge clk);
		require(rst === 1'b0, "reset never released");
		reset_state();
		register_access();
		single_dispatch();
		priority_order();
		gating();
		overflow();
		@(posedge clk);
		foreach (credits[q])
			require(credits[q] == QDEPTH, $sformatf("credits of queue %0d not all back", q));
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD     = 10,	// ns
	parameter int RST_CYCLES = 5
) (
	output logic clk,
	output logic rst
);
	// free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset high from time zero, released on a rising edge
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: hw/msi_controller.sv
`timescale 1ns/1ps

module msi_controller #(
	parameter int NQUES  = 7,	// priority queues, 8 at most
	parameter int QDEPTH = 4	// messages per queue
) (
	input  logic                          clk,
	input  logic                          rst,
	// device side
	input  logic                          msg_valid_i,
	input  msi_pkg::msi_msg_t             msg_i,
	output logic [NQUES-1:0]              credit_o,
	// register bus
	input  regbus_pkg::regbus_req_t       reg_req_i,
	output regbus_pkg::regbus_resp_t      reg_resp_o,
	// core side
	output logic                          irq_o,
	output msi_pkg::msi_ivect_t           ivect_o,
	output logic [msi_pkg::MSI_PRI_W-1:0] ipri_o,
	output logic [msi_pkg::MSI_STK_W-1:0] swstk_o,
	input  logic                          irq_ack_i
);
	import msi_pkg::*;

	logic [MSI_PRI_W-1:0]    msg_que;	// clamped target queue
	logic [NQUES-1:0]        fifo_wr;
	logic [NQUES-1:0]        fifo_empty;
	logic [NQUES-1:0]        fifo_full;
	logic [NQUES-1:0]        fifo_pop;
	msi_msg_t [NQUES-1:0]    fifo_head;

	logic                    global_en;
	logic [MSI_PRI_W-1:0]    threshold;
	logic [MSI_NVEC-1:0]     vec_en;

	logic                    tbl_a_en;
	logic                    tbl_a_we;
	logic [MSI_VEC_W-1:0]    tbl_a_addr;
	msi_vec_t                tbl_a_din;
	msi_vec_t                tbl_a_dout;
	logic [MSI_VEC_W-1:0]    tbl_b_addr;
	msi_vec_t                tbl_b_dout;

	assign msg_que  = msi_que_of(msg_i.pri, NQUES);
	assign credit_o = fifo_pop;	// every pop hands back a credit

	// ====================
	// priority queues
	// ====================
	for (genvar g = 0; g < NQUES; g++) begin : g_que
		assign fifo_wr[g] = msg_valid_i && (msg_que == MSI_PRI_W'(g));

		msi_prio_fifo #(
			.QDEPTH (QDEPTH)
		) u_fifo (
			.clk     (clk),
			.rst     (rst),
			.wr_i    (fifo_wr[g]),
			.din_i   (msg_i),
			.rd_i    (fifo_pop[g]),
			.dout_o  (fifo_head[g]),
			.empty_o (fifo_empty[g]),
			.full_o  (fifo_full[g])
		);
	end

	msi_dispatch #(
		.NQUES (NQUES)
	) u_dispatch (
		.clk         (clk),
		.rst         (rst),
		.empty_i     (fifo_empty),
		.head_i      (fifo_head),
		.global_en_i (global_en),
		.threshold_i (threshold),
		.vec_en_i    (vec_en),
		.tbl_entry_i (tbl_b_dout),
		.irq_ack_i   (irq_ack_i),
		.pop_o       (fifo_pop),
		.tbl_addr_o  (tbl_b_addr),
		.irq_o       (irq_o),
		.ivect_o     (ivect_o),
		.ipri_o      (ipri_o),
		.swstk_o     (swstk_o)
	);

	msi_regs #(
		.NQUES (NQUES)
	) u_regs (
		.clk         (clk),
		.rst         (rst),
		.req_i       (reg_req_i),
		.resp_o      (reg_resp_o),
		.msg_valid_i (msg_valid_i),
		.msg_i       (msg_i),
		.full_i      (fifo_full),
		.global_en_o (global_en),
		.threshold_o (threshold),
		.vec_en_o    (vec_en),
		.tbl_en_o    (tbl_a_en),
		.tbl_we_o    (tbl_a_we),
		.tbl_addr_o  (tbl_a_addr),
		.tbl_din_o   (tbl_a_din),
		.tbl_dout_i  (tbl_a_dout)
	);

	msi_vector_table u_vtbl (
		.clk      (clk),
		.a_en_i   (tbl_a_en),
		.a_we_i   (tbl_a_we),
		.a_addr_i (tbl_a_addr),
		.a_din_i  (tbl_a_din),
		.a_dout_o (tbl_a_dout),
		.b_addr_i (tbl_b_addr),
		.b_dout_o (tbl_b_dout)
	);

endmodule

// File: hw/msi_regs.sv
`timescale 1ns/1ps

module msi_regs #(
	parameter int NQUES = 7
) (
	input  logic                          clk,
	input  logic                          rst,
	// register bus
	input  regbus_pkg::regbus_req_t       req_i,
	output regbus_pkg::regbus_resp_t      resp_o,
	// message snoop
	input  logic                          msg_valid_i,
	input  msi_pkg::msi_msg_t             msg_i,
	input  logic [NQUES-1:0]              full_i,
	// to dispatcher
	output logic                          global_en_o,
	output logic [msi_pkg::MSI_PRI_W-1:0] threshold_o,
	output logic [msi_pkg::MSI_NVEC-1:0]  vec_en_o,
	// vector table port a
	output logic                          tbl_en_o,
	output logic                          tbl_we_o,
	output logic [msi_pkg::MSI_VEC_W-1:0] tbl_addr_o,
	output msi_pkg::msi_vec_t             tbl_din_o,
	input  msi_pkg::msi_vec_t             tbl_dout_i
);
	import msi_pkg::*;
	import regbus_pkg::*;

	logic                   gen_q;	// global enable
	logic [MSI_PRI_W-1:0]   thresh_q;
	logic [MSI_NVEC-1:0]    vec_en_q;
	logic [MSI_NVEC-1:0]    pend_q;
	logic [NQUES-1:0]       ovf_q;	// sticky overflow per queue

	logic                   wr_req;
	logic                   tbl_hit;
	logic [MSI_PRI_W-1:0]   msg_que;
	logic [MSI_NVEC-1:0]    pend_clr;
	logic [MSI_NVEC-1:0]    pend_set;
	logic [NQUES-1:0]       ovf_keep;
	logic [NQUES-1:0]       ovf_set;
	logic [REG_DATA_W-1:0]  rd_mux;

	logic                   resp_vld_q;
	logic                   tbl_rd_q;	// response comes from the table
	logic [REG_DATA_W-1:0]  rdata_q;

	assign wr_req  = req_i.valid & req_i.we;
	assign tbl_hit = (req_i.addr[7:6] == REG_VTBL[7:6]);	// 0x40..0x7f
	assign msg_que = msi_que_of(msg_i.pri, NQUES);

	// ====================
	// table port a
	// ====================
	assign tbl_en_o   = req_i.valid & tbl_hit;
	assign tbl_we_o   = wr_req & tbl_hit;
	assign tbl_addr_o = req_i.addr[MSI_VEC_W-1:0];
	assign tbl_din_o  = msi_vec_t'(req_i.wdata);

	// set and clear masks, a new message beats a same cycle clear
	always_comb begin
		pend_clr = '0;
		ovf_keep = '1;
		if (wr_req && req_i.addr == REG_PEND0)
			pend_clr[31:0] = req_i.wdata;	// write one to clear
		if (wr_req && req_i.addr == REG_PEND1)
			pend_clr[63:32] = req_i.wdata;
		if (wr_req && req_i.addr == REG_STATUS)
			ovf_keep = req_i.wdata[NQUES-1:0];	// write zero to clear
	end

	assign pend_set = msg_valid_i ? (MSI_NVEC'(1) << msg_i.vecno) : '0;
	assign ovf_set  = msg_valid_i ? (full_i & (NQUES'(1) << msg_que)) : '0;

	// ====================
	// control registers
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			gen_q    <= 1'b0;
			thresh_q <= '0;
			vec_en_q <= '0;
			pend_q   <= '0;
			ovf_q    <= '0;
		end else begin
			if (wr_req) begin
				case (req_i.addr)
					REG_CTRL: begin
						gen_q    <= req_i.wdata[0];
						thresh_q <= req_i.wdata[6:4];
					end
					REG_EN0: vec_en_q[31:0]  <= req_i.wdata;
					REG_EN1: vec_en_q[63:32] <= req_i.wdata;
					default: ;	// status/pend below, others ignored
				endcase
			end
			pend_q <= (pend_q & ~pend_clr) | pend_set;
			ovf_q  <= (ovf_q & ovf_keep) | ovf_set;
		end
	end

	assign global_en_o = gen_q;
	assign threshold_o = thresh_q;
	assign vec_en_o    = vec_en_q;

	// ====================
	// read path
	// ====================
	// values seen before this cycle's write
	always_comb begin
		case (req_i.addr)
			REG_CTRL:   rd_mux = {25'd0, thresh_q, 3'd0, gen_q};
			REG_STATUS: rd_mux = REG_DATA_W'(ovf_q);
			REG_EN0:    rd_mux = vec_en_q[31:0];
			REG_EN1:    rd_mux = vec_en_q[63:32];
			REG_PEND0:  rd_mux = pend_q[31:0];
			REG_PEND1:  rd_mux = pend_q[63:32];
			default:    rd_mux = '0;	// unmapped reads zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resp_vld_q <= 1'b0;
			tbl_rd_q   <= 1'b0;
		end else begin
			resp_vld_q <= req_i.valid;	// one response per request
			tbl_rd_q   <= req_i.valid & ~req_i.we & tbl_hit;
		end
	end

	always_ff @(posedge clk) begin
		rdata_q <= (req_i.valid && !req_i.we) ? rd_mux : '0;
	end

	// table data shows up with the response, straight from port a
	assign resp_o.valid = resp_vld_q;
	assign resp_o.rdata = tbl_rd_q ? REG_DATA_W'(tbl_dout_i) : rdata_q;

endmodule

// File: hw/msi_dispatch.sv
`timescale 1ns/1ps

module msi_dispatch #(
	parameter int NQUES = 7
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [NQUES-1:0]                    empty_i,
	input  msi_pkg::msi_msg_t [NQUES-1:0]       head_i,
	input  logic                                global_en_i,
	input  logic [msi_pkg::MSI_PRI_W-1:0]       threshold_i,
	input  logic [msi_pkg::MSI_NVEC-1:0]        vec_en_i,
	input  msi_pkg::msi_vec_t                   tbl_entry_i,
	input  logic                                irq_ack_i,
	output logic [NQUES-1:0]                    pop_o,
	output logic [msi_pkg::MSI_VEC_W-1:0]       tbl_addr_o,
	output logic                                irq_o,
	output msi_pkg::msi_ivect_t                 ivect_o,
	output logic [msi_pkg::MSI_PRI_W-1:0]       ipri_o,
	output logic [msi_pkg::MSI_STK_W-1:0]       swstk_o
);
	import msi_pkg::*;

	localparam int QW = (NQUES > 1) ? $clog2(NQUES) : 1;	// queue index width

	typedef enum logic [1:0] {
		ST_SELECT,	// pick a queue
		ST_LOOKUP,	// table read in flight
		ST_DECIDE,	// gate check
		ST_WAIT		// irq up until the ack
	} state_t;

	state_t          state_q;
	logic [QW-1:0]   sel_q;	// chosen queue
	logic [QW-1:0]   sel_nx;
	logic            found;	// some queue is eligible
	msi_msg_t        head_q;	// copy of the chosen head
	logic            gate_ok;
	logic            pop_now;

	// highest non-empty queue at or above threshold wins
	always_comb begin
		found  = 1'b0;
		sel_nx = '0;
		for (int q = 0; q < NQUES; q++) begin
			if (!empty_i[q] && q >= int'(threshold_i)) begin
				found  = 1'b1;
				sel_nx = QW'(q);
			end
		end
	end

	assign tbl_addr_o = head_q.vecno;	// port b address holds steady after select
	assign gate_ok    = global_en_i & tbl_entry_i.ie & vec_en_i[head_q.vecno];

	// head leaves on a discard or on the ack
	assign pop_now = ((state_q == ST_DECIDE) && !gate_ok) || ((state_q == ST_WAIT) && irq_ack_i);
	assign pop_o   = pop_now ? (NQUES'(1) << sel_q) : '0;

	// latch the chosen head until it is popped
	always_ff @(posedge clk) begin
		if (rst)
			head_q <= '0;
		else if (state_q == ST_SELECT && found)
			head_q <= head_i[sel_nx];
	end

	// ====================
	// sequence
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_SELECT;
			sel_q   <= '0;
			irq_o   <= 1'b0;
			ivect_o <= '0;
			ipri_o  <= '0;
			swstk_o <= '0;
		end else begin
			case (state_q)
				ST_SELECT: begin
					if (found) begin
						sel_q   <= sel_nx;
						state_q <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: state_q <= ST_DECIDE;	// entry lands next cycle
				ST_DECIDE: begin
					if (gate_ok) begin
						irq_o           <= 1'b1;
						ivect_o.handler <= tbl_entry_i.handler;
						ivect_o.data    <= head_q.data;
						ipri_o          <= MSI_PRI_W'(sel_q);	// clamped queue index
						swstk_o         <= tbl_entry_i.swstk;
						state_q         <= ST_WAIT;
					end else begin
						state_q <= ST_SELECT;	// dropped with its pending bit left set
					end
				end
				ST_WAIT: begin
					if (irq_ack_i) begin
						irq_o   <= 1'b0;
						state_q <= ST_SELECT;
					end
				end
				default: state_q <= ST_SELECT;
			endcase
		end
	end

endmodule

// File: hw/msi_vector_table.sv
`timescale 1ns/1ps

module msi_vector_table (
	input  logic                          clk,
	// register side
	input  logic                          a_en_i,
	input  logic                          a_we_i,
	input  logic [msi_pkg::MSI_VEC_W-1:0] a_addr_i,
	input  msi_pkg::msi_vec_t             a_din_i,
	output msi_pkg::msi_vec_t             a_dout_o,
	// dispatch side, read only
	input  logic [msi_pkg::MSI_VEC_W-1:0] b_addr_i,
	output msi_pkg::msi_vec_t             b_dout_o
);
	import msi_pkg::*;

	msi_vec_t mem [MSI_NVEC];	// one entry per vector

	// ====================
	// port a
	// ====================
	// read returns the old word on a write cycle
	always_ff @(posedge clk) begin
		if (a_en_i) begin
			if (a_we_i)
				mem[a_addr_i] <= a_din_i;
			a_dout_o <= mem[a_addr_i];
		end
	end

	// ====================
	// port b
	// ====================
	// lookup is always on, one cycle latency
	always_ff @(posedge clk) begin
		b_dout_o <= mem[b_addr_i];
	end

endmodule

// File: hw/msi_prio_fifo.sv
`timescale 1ns/1ps

module msi_prio_fifo #(
	parameter int QDEPTH = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wr_i,
	input  msi_pkg::msi_msg_t din_i,
	input  logic              rd_i,
	output msi_pkg::msi_msg_t dout_o,
	output logic              empty_o,
	output logic              full_o
);
	import msi_pkg::*;

	localparam int AW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;	// pointer width
	localparam int CW = $clog2(QDEPTH + 1);	// count has to reach QDEPTH

	msi_msg_t        mem [QDEPTH];	// message storage
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [CW-1:0]   count;	// messages held
	logic            do_wr;
	logic            do_rd;

	assign empty_o = (count == '0);
	assign full_o  = (count == CW'(QDEPTH));
	assign do_wr   = wr_i & ~full_o;	// dropped when full
	assign do_rd   = rd_i & ~empty_o;

	assign dout_o = mem[rd_ptr];	// head is always visible

	// new message goes in at the tail
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
	end

	// pointers wrap at QDEPTH, which need not be a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

endmodule

// File: hw/regbus_pkg.sv
package regbus_pkg;

	localparam int REG_ADDR_W = 8;	// word address
	localparam int REG_DATA_W = 32;

	// request, 42 bits
	typedef struct packed {
		logic                  valid;
		logic                  we;
		logic [REG_ADDR_W-1:0] addr;
		logic [REG_DATA_W-1:0] wdata;
	} regbus_req_t;

	// response, 33 bits, always one cycle after the request
	typedef struct packed {
		logic                  valid;
		logic [REG_DATA_W-1:0] rdata;
	} regbus_resp_t;

	// ====================
	// address map
	// ====================
	localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 8'h00;	// [0] global enable, [6:4] threshold
	localparam logic [REG_ADDR_W-1:0] REG_STATUS = 8'h01;	// sticky overflow per queue, w0c
	localparam logic [REG_ADDR_W-1:0] REG_EN0    = 8'h02;	// enables 0..31
	localparam logic [REG_ADDR_W-1:0] REG_EN1    = 8'h03;	// enables 32..63
	localparam logic [REG_ADDR_W-1:0] REG_PEND0  = 8'h04;	// pending 0..31, w1c
	localparam logic [REG_ADDR_W-1:0] REG_PEND1  = 8'h05;	// pending 32..63, w1c
	localparam logic [REG_ADDR_W-1:0] REG_VTBL   = 8'h40;	// vector table 0x40..0x7f

endpackage

// File: hw/msi_pkg.sv
package msi_pkg;

	// ====================
	// sizes
	// ====================
	localparam int MSI_NVEC   = 64;	// vectors in the table
	localparam int MSI_VEC_W  = 6;	// vector number width
	localparam int MSI_PRI_W  = 3;	// priority width
	localparam int MSI_DATA_W = 16;	// message payload handed to the core
	localparam int MSI_HND_W  = 28;	// handler word address
	localparam int MSI_STK_W  = 3;	// stack selector

	// one interrupt message as a device sends it, 25 bits
	typedef struct packed {
		logic [MSI_VEC_W-1:0]  vecno;	// which vector
		logic [MSI_PRI_W-1:0]  pri;	// requested priority
		logic [MSI_DATA_W-1:0] data;	// passed through untouched
	} msi_msg_t;

	// vector table entry, exactly one 32 bit register word
	typedef struct packed {
		logic                 ie;	// vector enable
		logic [MSI_STK_W-1:0] swstk;	// stack to switch to
		logic [MSI_HND_W-1:0] handler;	// handler word address
	} msi_vec_t;

	// what the core gets with irq
	typedef struct packed {
		logic [MSI_HND_W-1:0]  handler;
		logic [MSI_DATA_W-1:0] data;
	} msi_ivect_t;

	// map a message priority onto a queue index
	// anything at or past the last queue lands in the last queue
	function automatic logic [MSI_PRI_W-1:0] msi_que_of(
		input logic [MSI_PRI_W-1:0] pri,
		input int                   nques
	);
		if (int'(pri) >= nques)
			return MSI_PRI_W'(nques - 1);
		return pri;
	endfunction

endpackage
